/* verilog/fpadd_pkg.sv */
`default_nettype none

package fpadd_pkg;

	// single precision format
	localparam int EXP_W  = 8;
	localparam int MANT_W = 24;

	// carry + significand + guard, round, sticky
	localparam int SIG_W  = MANT_W + 4;

	// exception field, same encoding as the adder core
	typedef enum logic [1:0]
	{
		EXC_ZERO   = 2'd0,
		EXC_NORMAL = 2'd1,
		EXC_INF    = 2'd2,
		EXC_NAN    = 2'd3
	} exc_e;

	typedef enum logic
	{
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} fp_op_e;

	// byte offsets on the register bus
	typedef enum logic [7:0]
	{
		REG_OP_A   = 8'h00,
		REG_OP_B   = 8'h04,
		REG_CTRL   = 8'h08,
		REG_RESULT = 8'h0C,
		REG_STATUS = 8'h10
	} reg_addr_e;

	// quiet NaN returned for every invalid result
	localparam logic [31:0] QNAN_WORD = 32'h7FC0_0000;

endpackage

`default_nettype wire

/* verilog/fpadd_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

// operands leaving the register block
interface fp_launch_if import fpadd_pkg::*; ();
	logic                valid;
	fp_op_e              op;
	exc_e                a_exc;
	logic                a_sign;
	logic [EXP_W-1:0]    a_exp;
	logic [MANT_W-2:0]   a_frac;
	exc_e                b_exc;
	logic                b_sign;
	logic [EXP_W-1:0]    b_exp;
	logic [MANT_W-2:0]   b_frac;

	modport src (output valid, op, a_exc, a_sign, a_exp, a_frac, b_exc, b_sign, b_exp, b_frac);
	modport dst (input valid, op, a_exc, a_sign, a_exp, a_frac, b_exc, b_sign, b_exp, b_frac);
endinterface

// aligned significands
interface fp_align_if import fpadd_pkg::*; ();
	logic                valid;
	logic                eff_sub;
	logic [EXP_W-1:0]    exp_big;
	logic [SIG_W-1:0]    sig_big;
	logic [SIG_W-1:0]    sig_small;
	logic                sign_big;
	logic                swap;
	logic                special;
	exc_e                sp_exc;
	logic                sp_sign;

	modport src (output valid, eff_sub, exp_big, sig_big, sig_small, sign_big, swap,
		special, sp_exc, sp_sign);
	modport dst (input valid, eff_sub, exp_big, sig_big, sig_small, sign_big, swap,
		special, sp_exc, sp_sign);
endinterface

// normalized result before rounding
interface fp_norm_if import fpadd_pkg::*; ();
	logic                   valid;
	logic                   sign;
	logic signed [EXP_W+1:0] exp;
	logic [SIG_W-2:0]       sig;
	logic                   zero;
	logic                   special;
	exc_e                   sp_exc;

	modport src (output valid, sign, exp, sig, zero, special, sp_exc);
	modport dst (input valid, sign, exp, sig, zero, special, sp_exc);
endinterface

`default_nettype wire

/* verilog/fp_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_apb_regs import fpadd_pkg::*;
#(
	parameter int APB_ADDR_W = 8
)
(
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [31:0]           pwdata_i,
	output logic [31:0]           prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	input  logic                  res_valid_i,
	input  logic [31:0]           res_word_i,
	fp_launch_if.src              launch
);

	logic [31:0] op_a_q;
	logic [31:0] op_b_q;
	logic [31:0] result_q;
	logic        valid_q;
	logic        overrun_q;
	logic [7:0]  done_cnt_q;
	logic        access;
	logic        hit_a;
	logic        hit_b;
	logic        hit_ctrl;
	logic        hit_res;
	logic        hit_stat;
	logic        addr_ok;
	logic        ctrl_wr;
	logic        result_rd;

	// IEEE word to exception field, subnormals flush to zero
	function automatic exc_e classify(input logic [31:0] w);
		if (w[30:23] == '0)
			classify = EXC_ZERO;
		else if (w[30:23] == '1)
			classify = (w[22:0] == '0) ? EXC_INF : EXC_NAN;
		else
			classify = EXC_NORMAL;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// address decode
	assign access   = psel_i & penable_i;
	assign hit_a    = (paddr_i == APB_ADDR_W'(REG_OP_A));
	assign hit_b    = (paddr_i == APB_ADDR_W'(REG_OP_B));
	assign hit_ctrl = (paddr_i == APB_ADDR_W'(REG_CTRL));
	assign hit_res  = (paddr_i == APB_ADDR_W'(REG_RESULT));
	assign hit_stat = (paddr_i == APB_ADDR_W'(REG_STATUS));
	assign addr_ok  = hit_a | hit_b | hit_ctrl | hit_res | hit_stat;

	assign pready_o  = 1'b1;
	assign pslverr_o = access & (~addr_ok | (pwrite_i & hit_res));
	assign ctrl_wr   = access & pwrite_i & hit_ctrl;
	assign result_rd = access & ~pwrite_i & hit_res;

	// ctrl is write only and reads as zero
	always_comb
	begin
		if (hit_a)
			prdata_o = op_a_q;
		else if (hit_b)
			prdata_o = op_b_q;
		else if (hit_res)
			prdata_o = result_q;
		else if (hit_stat)
			prdata_o = {16'h0000, done_cnt_q, 6'b000000, overrun_q, valid_q};
		else
			prdata_o = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// operands and launch
	always_ff @(posedge clk_i)
	begin
		if (access && pwrite_i && hit_a)
			op_a_q <= pwdata_i;
		if (access && pwrite_i && hit_b)
			op_b_q <= pwdata_i;
		if (ctrl_wr)
		begin
			launch.op     <= fp_op_e'(pwdata_i[0]);
			launch.a_exc  <= classify(op_a_q);
			launch.a_sign <= op_a_q[31];
			launch.a_exp  <= op_a_q[EXP_W+MANT_W-2:MANT_W-1];
			launch.a_frac <= op_a_q[MANT_W-2:0];
			launch.b_exc  <= classify(op_b_q);
			launch.b_sign <= op_b_q[31];
			launch.b_exp  <= op_b_q[EXP_W+MANT_W-2:MANT_W-1];
			launch.b_frac <= op_b_q[MANT_W-2:0];
		end
	end

	// result capture and status
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			launch.valid <= 1'b0;
			result_q     <= '0;
			valid_q      <= 1'b0;
			overrun_q    <= 1'b0;
			done_cnt_q   <= '0;
		end
		else
		begin
			launch.valid <= ctrl_wr;
			if (res_valid_i)
			begin
				result_q   <= res_word_i;
				done_cnt_q <= done_cnt_q + 8'd1;
			end
			if (res_valid_i)
				valid_q <= 1'b1;
			else if (result_rd)
				valid_q <= 1'b0;
			// unread result replaced
			if (res_valid_i && valid_q && !result_rd)
				overrun_q <= 1'b1;
			else if (access && pwrite_i && hit_stat && pwdata_i[1])
				overrun_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/fp_align_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_align_stage import fpadd_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_n_i,
	fp_launch_if.dst launch,
	fp_align_if.src  align
);

	logic             b_eff_sign;
	logic             eff_sub;
	logic [EXP_W:0]   a_minus_b;
	logic [EXP_W:0]   b_minus_a;
	logic             a_zero;
	logic             b_zero;
	logic             sel_b;
	logic [EXP_W-1:0] shamt;
	logic [SIG_W-1:0] big_ext;
	logic [SIG_W-1:0] small_ext;
	logic [SIG_W-1:0] shifted;
	logic             lost;
	logic             special;
	exc_e             sp_exc;
	logic             sp_sign;

	// effective operation from both signs and the opcode
	assign b_eff_sign = launch.b_sign ^ (launch.op == OP_SUB);
	assign eff_sub    = launch.a_sign ^ b_eff_sign;

	assign a_minus_b = {1'b0, launch.a_exp} - {1'b0, launch.b_exp};
	assign b_minus_a = {1'b0, launch.b_exp} - {1'b0, launch.a_exp};
	assign a_zero    = (launch.a_exc == EXC_ZERO);
	assign b_zero    = (launch.b_exc == EXC_ZERO);

	// b on top when its exponent wins or a is zero
	assign sel_b = a_zero | (~b_zero & a_minus_b[EXP_W]);
	assign shamt = sel_b ? b_minus_a[EXP_W-1:0] : a_minus_b[EXP_W-1:0];

	assign big_ext   = sel_b ? {2'b01, launch.b_frac, 3'b000} : {2'b01, launch.a_frac, 3'b000};
	assign small_ext = (a_zero | b_zero) ? '0 :
		(sel_b ? {2'b01, launch.a_frac, 3'b000} : {2'b01, launch.b_frac, 3'b000});

	////////////////////////////////////////////////////////////////////////////
	// right shift, bits falling off collapse into sticky
	always_comb
	begin
		if (shamt >= EXP_W'(SIG_W))
		begin
			shifted = '0;
			lost    = |small_ext;
		end
		else
		begin
			shifted = small_ext >> shamt;
			lost    = |(small_ext & ~({SIG_W{1'b1}} << shamt));
		end
	end

	// NaN, infinity and double zero bypass the datapath
	always_comb
	begin
		special = 1'b1;
		sp_exc  = EXC_NAN;
		sp_sign = 1'b0;
		if (launch.a_exc == EXC_NAN || launch.b_exc == EXC_NAN)
			sp_exc = EXC_NAN;
		else if (launch.a_exc == EXC_INF && launch.b_exc == EXC_INF)
		begin
			sp_exc  = eff_sub ? EXC_NAN : EXC_INF;
			sp_sign = eff_sub ? 1'b0 : launch.a_sign;
		end
		else if (launch.a_exc == EXC_INF)
		begin
			sp_exc  = EXC_INF;
			sp_sign = launch.a_sign;
		end
		else if (launch.b_exc == EXC_INF)
		begin
			sp_exc  = EXC_INF;
			sp_sign = b_eff_sign;
		end
		else if (a_zero && b_zero)
		begin
			// -0 only when both are negative
			sp_exc  = EXC_ZERO;
			sp_sign = launch.a_sign & b_eff_sign;
		end
		else
		begin
			special = 1'b0;
			sp_exc  = EXC_NORMAL;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			align.valid <= 1'b0;
		else
			align.valid <= launch.valid;
	end

	always_ff @(posedge clk_i)
	begin
		align.eff_sub   <= eff_sub;
		align.exp_big   <= sel_b ? launch.b_exp : launch.a_exp;
		align.sig_big   <= big_ext;
		align.sig_small <= {shifted[SIG_W-1:1], shifted[0] | lost};
		align.sign_big  <= sel_b ? b_eff_sign : launch.a_sign;
		align.swap      <= sel_b;
		align.special   <= special;
		align.sp_exc    <= sp_exc;
		align.sp_sign   <= sp_sign;
	end

endmodule

`default_nettype wire

/* verilog/fp_add_norm_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_add_norm_stage import fpadd_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_n_i,
	fp_align_if.dst align,
	fp_norm_if.src  norm
);

	localparam int LZ_W = $clog2(SIG_W);

	logic [SIG_W:0]          raw;
	logic                    neg;
	logic [SIG_W-1:0]        mag;
	logic [LZ_W-1:0]         lz;
	logic [SIG_W-2:0]        norm_sig;
	logic [EXP_W+1:0]        exp_ext;
	logic [EXP_W+1:0]        norm_exp;
	logic                    is_zero;
	logic                    res_sign;

	function automatic logic [LZ_W-1:0] count_lz(input logic [SIG_W-2:0] v);
		logic [LZ_W-1:0] n;
		logic            done;
		n    = '0;
		done = 1'b0;
		for (int i = SIG_W - 2; i >= 0; i--)
		begin
			if (!done && !v[i])
				n = n + 1'b1;
			else
				done = 1'b1;
		end
		count_lz = n;
	endfunction

	assign raw = align.eff_sub ? ({1'b0, align.sig_big} - {1'b0, align.sig_small}) :
		({1'b0, align.sig_big} + {1'b0, align.sig_small});

	// only equal exponents can borrow, a swapped pair never does
	assign neg = raw[SIG_W] & ~align.swap;
	assign mag = neg ? (~raw[SIG_W-1:0] + 1'b1) : raw[SIG_W-1:0];

	assign lz      = count_lz(mag[SIG_W-2:0]);
	assign is_zero = (mag == '0);
	assign exp_ext = {2'b00, align.exp_big};

	// carry out shifts right once, otherwise shift left by lz
	always_comb
	begin
		if (mag[SIG_W-1])
		begin
			norm_sig = {mag[SIG_W-1:2], |mag[1:0]};
			norm_exp = exp_ext + 1'b1;
		end
		else
		begin
			norm_sig = mag[SIG_W-2:0] << lz;
			norm_exp = exp_ext - (EXP_W + 2)'(lz);
		end
	end

	always_comb
	begin
		if (align.special)
			res_sign = align.sp_sign;
		else if (is_zero)
			res_sign = align.eff_sub ? 1'b0 : align.sign_big;
		else
			res_sign = align.sign_big ^ neg;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			norm.valid <= 1'b0;
		else
			norm.valid <= align.valid;
	end

	always_ff @(posedge clk_i)
	begin
		norm.sign    <= res_sign;
		norm.exp     <= norm_exp;
		norm.sig     <= norm_sig;
		norm.zero    <= is_zero;
		norm.special <= align.special;
		norm.sp_exc  <= align.sp_exc;
	end

endmodule

`default_nettype wire

/* verilog/fp_round_pack_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_round_pack_stage import fpadd_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	fp_norm_if.dst      norm,
	output logic        res_valid_o,
	output logic [31:0] res_word_o
);

	localparam logic signed [EXP_W+1:0] EXP_MAX = (EXP_W + 2)'((1 << EXP_W) - 1);

	logic                    round_up;
	logic [MANT_W:0]         rounded;
	logic [MANT_W-2:0]       frac;
	logic signed [EXP_W+1:0] exp_adj;
	exc_e                    res_exc;
	logic [31:0]             word;

	// nearest even, ties go to an even lsb
	assign round_up = norm.sig[2] & (norm.sig[1] | norm.sig[0] | norm.sig[3]);
	assign rounded  = {1'b0, norm.sig[SIG_W-2:3]} + (MANT_W + 1)'(round_up);

	// rounding carry needs one more exponent step
	always_comb
	begin
		if (rounded[MANT_W])
		begin
			frac    = rounded[MANT_W-1:1];
			exp_adj = norm.exp + 1'b1;
		end
		else
		begin
			frac    = rounded[MANT_W-2:0];
			exp_adj = norm.exp;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// final exception field
	always_comb
	begin
		if (norm.special)
			res_exc = norm.sp_exc;
		else if (norm.zero || exp_adj <= 0)
			res_exc = EXC_ZERO;
		else if (exp_adj >= EXP_MAX)
			res_exc = EXC_INF;
		else
			res_exc = EXC_NORMAL;
	end

	always_comb
	begin
		case (res_exc)
			EXC_ZERO:
				word = {norm.sign, 31'b0};
			EXC_INF:
				word = {norm.sign, {EXP_W{1'b1}}, {(MANT_W - 1){1'b0}}};
			EXC_NAN:
				word = QNAN_WORD;
			default:
				word = {norm.sign, exp_adj[EXP_W-1:0], frac};
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= norm.valid;
	end

	always_ff @(posedge clk_i)
	begin
		res_word_o <= word;
	end

endmodule

`default_nettype wire

/* verilog/fp_adder_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fp_adder_top
#(
	parameter int APB_ADDR_W = 8
)
(
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [31:0]           pwdata_i,
	output logic [31:0]           prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o
);

	fp_launch_if launch_bus ();
	fp_align_if  align_bus ();
	fp_norm_if   norm_bus ();

	logic        res_valid;
	logic [31:0] res_word;

	fp_apb_regs #(.APB_ADDR_W(APB_ADDR_W)) i_regs
	(
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.res_valid_i (res_valid),
		.res_word_i  (res_word),
		.launch      (launch_bus.src)
	);

	// three stage adder pipeline
	fp_align_stage i_align
	(
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.launch  (launch_bus.dst),
		.align   (align_bus.src)
	);

	fp_add_norm_stage i_add_norm
	(
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.align   (align_bus.dst),
		.norm    (norm_bus.src)
	);

	fp_round_pack_stage i_round_pack
	(
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.norm        (norm_bus.dst),
		.res_valid_o (res_valid),
		.res_word_o  (res_word)
	);

endmodule

`default_nettype wire

/* verif/tb_fp_adder.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fp_adder import fpadd_pkg::*;
;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_PAT    = 24;
	localparam int WRAP_N     = 240;
	localparam int POLL_LIMIT = 20;
	// each pattern needs about 30 cycles, each burst launch 3
	localparam int WATCHDOG_CYCLES = NUM_PAT * 40 + WRAP_N * 4 + 400;

	logic        clk;
	logic        rst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// A, B, opcode, expected result per pattern
	logic [31:0] pat_mem [0:NUM_PAT*4-1];
	logic [7:0]  lfsr;
	int          word_errs;
	int          status_errs;
	int          bus_errs;
	int          other_errs;
	int          launches;

	fp_adder_top #(.APB_ADDR_W(8)) i_dut
	(
		.clk_i     (clk),
		.rst_n_i   (rst_n),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Error: timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// taps 8,6,5,4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		lfsr_next = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic idle_gap();
		int n;
		n = 0;
		for (int k = 0; k < 3; k++)
		begin
			n = (n << 1) | lfsr[7];
			lfsr = lfsr_next(lfsr);
		end
		repeat (n) @(negedge clk);
	endtask

	// setup phase, access phase, then back to idle
	task automatic bus_cycle(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err   = pslverr;
		if (pready !== 1'b1)
		begin
			other_errs++;
			$display("Error: pready low during access to offset %02h", addr);
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		bus_cycle(1'b0, addr, 32'h0, data, err);
	endtask

	// poll STATUS until the completion count reaches the expected value
	task automatic wait_done(input string name, input logic [7:0] exp_cnt,
		output logic [31:0] stat);
		int   polls;
		logic err;
		polls = 0;
		apb_read(REG_STATUS, stat, err);
		while (stat[15:8] != exp_cnt && polls < POLL_LIMIT)
		begin
			polls++;
			apb_read(REG_STATUS, stat, err);
		end
		if (stat[15:8] != exp_cnt)
		begin
			other_errs++;
			$display("Error: %s never completed, status stuck at %08h", name, stat);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			word_errs++;
			$display("Fail %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic exp_valid, input logic exp_ovr,
		input logic [7:0] exp_cnt, input logic [31:0] act);
		if (act !== {16'h0, exp_cnt, 6'h0, exp_ovr, exp_valid})
		begin
			status_errs++;
			$display("Fail %s: expected valid %0b overrun %0b count %0d, actual %08h",
				name, exp_valid, exp_ovr, exp_cnt, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			bus_errs++;
			$display("Fail %s: expected pslverr %0b, actual %0b", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		logic [31:0] rdata;
		logic [31:0] stat;
		logic        err;
		string       name;
		rst_n       = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		lfsr        = 8'd72;
		word_errs   = 0;
		status_errs = 0;
		bus_errs    = 0;
		other_errs  = 0;
		launches    = 0;
		for (int i = 0; i < NUM_PAT * 4; i++)
			pat_mem[i] = 'x;
		$readmemh("verif/fp_adder_patterns.txt", pat_mem);
		if (^pat_mem[NUM_PAT*4-1] === 1'bx)
		begin
			other_errs++;
			$display("Error: pattern file missing or shorter than %0d lines", NUM_PAT);
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// reset values
		apb_read(REG_STATUS, stat, err);
		check_status("reset_status", 1'b0, 1'b0, 8'd0, stat);
		check_err("reset_status_err", 1'b0, err);
		apb_read(REG_RESULT, rdata, err);
		check_word("reset_result", 32'h0, rdata);

		// operand readback and rejected accesses
		apb_write(REG_OP_A, 32'hA5A5_0F0F, err);
		check_err("wr_op_a", 1'b0, err);
		apb_write(REG_OP_B, 32'h5A5A_F0F0, err);
		check_err("wr_op_b", 1'b0, err);
		apb_write(REG_RESULT, 32'hDEAD_BEEF, err);
		check_err("wr_result", 1'b1, err);
		apb_write(8'h14, 32'h0000_0003, err);
		check_err("wr_unmapped", 1'b1, err);
		apb_read(8'h20, rdata, err);
		check_err("rd_unmapped", 1'b1, err);
		apb_read(REG_OP_A, rdata, err);
		check_word("rd_op_a", 32'hA5A5_0F0F, rdata);
		apb_read(REG_OP_B, rdata, err);
		check_word("rd_op_b", 32'h5A5A_F0F0, rdata);
		apb_read(REG_RESULT, rdata, err);
		check_word("result_kept", 32'h0, rdata);
		apb_read(REG_STATUS, stat, err);
		check_status("status_kept", 1'b0, 1'b0, 8'd0, stat);

		// one operation per pattern
		for (int i = 0; i < NUM_PAT; i++)
		begin
			name = $sformatf("pat%0d", i);
			idle_gap();
			apb_write(REG_OP_A, pat_mem[4*i], err);
			apb_write(REG_OP_B, pat_mem[4*i+1], err);
			apb_write(REG_CTRL, pat_mem[4*i+2], err);
			launches++;
			wait_done(name, 8'(launches % 256), stat);
			check_status({name, "_done"}, 1'b1, 1'b0, 8'(launches % 256), stat);
			apb_read(REG_RESULT, rdata, err);
			check_word(name, pat_mem[4*i+3], rdata);
			apb_read(REG_STATUS, stat, err);
			check_status({name, "_read"}, 1'b0, 1'b0, 8'(launches % 256), stat);
		end

		// two launches without a read
		for (int i = 0; i < 2; i++)
		begin
			apb_write(REG_OP_A, pat_mem[4*i], err);
			apb_write(REG_OP_B, pat_mem[4*i+1], err);
			apb_write(REG_CTRL, pat_mem[4*i+2], err);
			launches++;
		end
		wait_done("overrun", 8'(launches % 256), stat);
		check_status("overrun_set", 1'b1, 1'b1, 8'(launches % 256), stat);
		apb_read(REG_RESULT, rdata, err);
		check_word("overrun_result", pat_mem[7], rdata);
		apb_write(REG_STATUS, 32'h0000_0002, err);
		check_err("wr_status", 1'b0, err);
		apb_read(REG_STATUS, stat, err);
		check_status("overrun_clear", 1'b0, 1'b0, 8'(launches % 256), stat);

		// burst past 256 completions, operands still from pattern 1
		for (int i = 0; i < WRAP_N; i++)
		begin
			apb_write(REG_CTRL, pat_mem[6], err);
			launches++;
		end
		wait_done("wrap", 8'(launches % 256), stat);
		check_status("count_wrap", 1'b1, 1'b1, 8'(launches % 256), stat);
		apb_read(REG_RESULT, rdata, err);
		check_word("wrap_result", pat_mem[7], rdata);

		repeat (4) @(negedge clk);
		$display("errors: word %0d, status %0d, bus %0d, other %0d",
			word_errs, status_errs, bus_errs, other_errs);
		if (word_errs + status_errs + bus_errs + other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/fp_adder_patterns.txt */
// columns: operand A, operand B, opcode (0 add, 1 sub), expected result
// IEEE-754 single, nearest even, subnormals flushed to zero
3F800000 40000000 00000000 40400000
3F800000 40000000 00000001 BF800000
3FC00000 3FC00000 00000000 40400000
41200000 C0600000 00000000 40D00000
3F800000 33800000 00000000 3F800000
3F800001 33800000 00000000 3F800002
3F800000 33800001 00000000 3F800001
3FFFFFFF 33800000 00000000 40000000
40400000 40400000 00000001 00000000
C0400000 40400000 00000000 00000000
80000000 80000000 00000000 80000000
3F800000 3F7FFFFF 00000001 33800000
3FC00000 3FE00000 00000001 BE800000
7F800001 3F800000 00000000 7FC00000
7F800000 7F800000 00000001 7FC00000
FF800000 3F800000 00000000 FF800000
3F800000 7F800000 00000001 FF800000
00000000 40A00000 00000001 C0A00000
40A00000 00400000 00000001 40A00000
7F7FFFFF 7F7FFFFF 00000000 7F800000
FF7FFFFF FF7FFFFF 00000000 FF800000
7F7FFFFF 73000000 00000000 7F800000
00800001 00800000 00000001 00000000
80800001 80800000 00000001 80000000

/* sim.f */
verilog/fpadd_pkg.sv
verilog/fpadd_ifs.sv
verilog/fp_apb_regs.sv
verilog/fp_align_stage.sv
verilog/fp_add_norm_stage.sv
verilog/fp_round_pack_stage.sv
verilog/fp_adder_top.sv
verif/tb_fp_adder.sv

/* Bender.yml */
package:
  name: fp_adder

sources:
  - verilog/fpadd_pkg.sv
  - verilog/fpadd_ifs.sv
  - verilog/fp_apb_regs.sv
  - verilog/fp_align_stage.sv
  - verilog/fp_add_norm_stage.sv
  - verilog/fp_round_pack_stage.sv
  - verilog/fp_adder_top.sv
  - target: test
    files:
      - verif/tb_fp_adder.sv
